// ==== include/ex_cfg.svh ====
// execute stage width, issue width, register index and jump opcode macros
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath width, RV32
`define EX_XLEN 32

// number of issue ways
`define EX_ISSUE_WIDTH 2

// architectural register index
`define EX_REG_IDX_W 5

// way index, wide enough for EX_ISSUE_WIDTH
`define EX_SLOT_W 1

// major opcodes, inst[6:0]
`define EX_OP_JAL  7'b1101111
`define EX_OP_JALR 7'b1100111

`endif

// ==== src/ex_pkg.sv ====
// execute stage enums and packed structs: packets, forwarding control, redirect
`include "ex_cfg.svh"

package ex_pkg;

    //////////////////////////////
    // enums
    //////////////////////////////

    // ALU function, 14 of 16 codes used
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_MUL    = 4'd10,
        ALU_MULH   = 4'd11,
        ALU_MULHSU = 4'd12,
        ALU_MULHU  = 4'd13
    } alu_func_e;

    // operand A source
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_NPC  = 2'd1,
        OPA_IS_PC   = 2'd2,
        OPA_IS_ZERO = 2'd3
    } opa_sel_e;

    // operand B source, rs2 or one of the immediate formats
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    // where a source operand comes from
    typedef enum logic [1:0] {
        FWD_NONE   = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2
    } fwd_src_e;

    // branch funct3 encodings, inst[14:12]
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_cond_e;

    //////////////////////////////
    // packets
    //////////////////////////////

    // one way of the ID/EX register
    typedef struct packed {
        logic                     valid;
        logic [`EX_XLEN-1:0]      pc;
        logic [`EX_XLEN-1:0]      npc;
        logic [31:0]              inst;
        logic [`EX_XLEN-1:0]      rs1_value;
        logic [`EX_XLEN-1:0]      rs2_value;
        opa_sel_e                 opa_sel;
        opb_sel_e                 opb_sel;
        alu_func_e                alu_func;
        logic                     cond_branch;
        logic                     uncond_branch;
        logic [`EX_REG_IDX_W-1:0] dest_reg_idx;
    } id_ex_slot_t;

    // forwarding control per way, slot picks the producing way
    typedef struct packed {
        fwd_src_e               src_a;
        logic [`EX_SLOT_W-1:0]  slot_a;
        fwd_src_e               src_b;
        logic [`EX_SLOT_W-1:0]  slot_b;
    } fwd_ctrl_t;

    // one way of the EX/MEM register
    typedef struct packed {
        logic                     valid;
        logic [`EX_XLEN-1:0]      alu_result;
        logic                     take_branch;
        logic [`EX_REG_IDX_W-1:0] dest_reg_idx;
    } ex_result_t;

    // fetch redirect
    typedef struct packed {
        logic                taken;
        logic [`EX_XLEN-1:0] target;
    } redirect_t;

endpackage

// ==== src/alu.sv ====
// combinational RV32IM ALU: add/sub, logic, compares, shifts, multiplies
`timescale 1ns/1ps
`include "ex_cfg.svh"

module alu (
    input  logic [`EX_XLEN-1:0] opa,
    input  logic [`EX_XLEN-1:0] opb,
    input  ex_pkg::alu_func_e   func,
    output logic [`EX_XLEN-1:0] result
);
    import ex_pkg::*;

    // full-width products for the high multiply forms
    logic signed [2*`EX_XLEN-1:0] signed_mul;
    logic signed [2*`EX_XLEN+1:0] mixed_mul;
    logic        [2*`EX_XLEN-1:0] unsigned_mul;
    logic                         slt_bit;
    logic                         sltu_bit;
    logic        [4:0]            shamt;

    assign signed_mul   = $signed(opa) * $signed(opb);
    // opa signed, opb zero extended by one bit
    assign mixed_mul    = $signed({opa[`EX_XLEN-1], opa}) * $signed({1'b0, opb});
    assign unsigned_mul = opa * opb;

    assign slt_bit  = $signed(opa) < $signed(opb);
    assign sltu_bit = opa < opb;
    // only low five bits count for RV32 shifts
    assign shamt    = opb[4:0];

    always_comb begin
        case (func)
            ALU_ADD:    result = opa + opb;
            ALU_SUB:    result = opa - opb;
            ALU_AND:    result = opa & opb;
            ALU_OR:     result = opa | opb;
            ALU_XOR:    result = opa ^ opb;
            ALU_SLT:    result = {{(`EX_XLEN-1){1'b0}}, slt_bit};
            ALU_SLTU:   result = {{(`EX_XLEN-1){1'b0}}, sltu_bit};
            ALU_SLL:    result = opa << shamt;
            ALU_SRL:    result = opa >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:    result = $signed(opa) >>> shamt;
            ALU_MUL:    result = signed_mul[`EX_XLEN-1:0];
            ALU_MULH:   result = signed_mul[2*`EX_XLEN-1:`EX_XLEN];
            ALU_MULHSU: result = mixed_mul[2*`EX_XLEN-1:`EX_XLEN];
            ALU_MULHU:  result = unsigned_mul[2*`EX_XLEN-1:`EX_XLEN];
            // spare codes
            default:    result = '0;
        endcase
    end

endmodule

// ==== src/operand_select.sv ====
// per-way forwarding muxes, RV32 immediate decode and ALU operand A/B selection
`timescale 1ns/1ps
`include "ex_cfg.svh"

module operand_select (
    input  ex_pkg::id_ex_slot_t  slot_in,
    input  ex_pkg::fwd_ctrl_t    fwd,
    input  ex_pkg::ex_result_t   ex_mem_q [`EX_ISSUE_WIDTH-1:0],
    input  logic [`EX_XLEN-1:0]  mem_wb_data [`EX_ISSUE_WIDTH-1:0],
    output logic [`EX_XLEN-1:0]  rs1_fwd,
    output logic [`EX_XLEN-1:0]  rs2_fwd,
    output logic [`EX_XLEN-1:0]  opa,
    output logic [`EX_XLEN-1:0]  opb
);
    import ex_pkg::*;

    logic [31:0]         inst;
    logic [`EX_XLEN-1:0] imm_i;
    logic [`EX_XLEN-1:0] imm_s;
    logic [`EX_XLEN-1:0] imm_b;
    logic [`EX_XLEN-1:0] imm_u;
    logic [`EX_XLEN-1:0] imm_j;

    // one forwarding mux, used for rs1 and rs2
    function automatic logic [`EX_XLEN-1:0] fwd_pick(
        input fwd_src_e            src,
        input logic [`EX_XLEN-1:0] ex_mem_value,
        input logic [`EX_XLEN-1:0] mem_wb_value,
        input logic [`EX_XLEN-1:0] reg_value
    );
        case (src)
            FWD_EX_MEM: fwd_pick = ex_mem_value;
            FWD_MEM_WB: fwd_pick = mem_wb_value;
            default:    fwd_pick = reg_value;
        endcase
    endfunction

    //////////////////////////////
    // forwarding
    //////////////////////////////

    // ex_mem source is the stage's own output register
    assign rs1_fwd = fwd_pick(fwd.src_a, ex_mem_q[fwd.slot_a].alu_result,
                              mem_wb_data[fwd.slot_a], slot_in.rs1_value);
    assign rs2_fwd = fwd_pick(fwd.src_b, ex_mem_q[fwd.slot_b].alu_result,
                              mem_wb_data[fwd.slot_b], slot_in.rs2_value);

    //////////////////////////////
    // immediates
    //////////////////////////////

    assign inst  = slot_in.inst;
    // all sign extended from inst[31]
    assign imm_i = {{(`EX_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`EX_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`EX_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    // upper immediate, low 12 bits zero
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{(`EX_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // operand A
    always_comb begin
        case (slot_in.opa_sel)
            OPA_IS_RS1:  opa = rs1_fwd;
            OPA_IS_NPC:  opa = slot_in.npc;
            OPA_IS_PC:   opa = slot_in.pc;
            default:     opa = '0;
        endcase
    end

    // operand B, unused selects give zero
    always_comb begin
        case (slot_in.opb_sel)
            OPB_IS_RS2:   opb = rs2_fwd;
            OPB_IS_I_IMM: opb = imm_i;
            OPB_IS_S_IMM: opb = imm_s;
            OPB_IS_B_IMM: opb = imm_b;
            OPB_IS_U_IMM: opb = imm_u;
            OPB_IS_J_IMM: opb = imm_j;
            default:      opb = '0;
        endcase
    end

endmodule

// ==== src/exec_lane.sv ====
// one issue way: operand select, ALU, branch condition and take-branch
`timescale 1ns/1ps
`include "ex_cfg.svh"

module exec_lane (
    input  ex_pkg::id_ex_slot_t  slot_in,
    input  ex_pkg::fwd_ctrl_t    fwd,
    input  ex_pkg::ex_result_t   ex_mem_q [`EX_ISSUE_WIDTH-1:0],
    input  logic [`EX_XLEN-1:0]  mem_wb_data [`EX_ISSUE_WIDTH-1:0],
    output ex_pkg::ex_result_t   result
);
    import ex_pkg::*;

    logic [`EX_XLEN-1:0] rs1_fwd;
    logic [`EX_XLEN-1:0] rs2_fwd;
    logic [`EX_XLEN-1:0] opa;
    logic [`EX_XLEN-1:0] opb;
    logic [`EX_XLEN-1:0] alu_out;
    br_cond_e            br_func;
    logic                cond_true;

    operand_select u_operand_select (
        .slot_in     (slot_in),
        .fwd         (fwd),
        .ex_mem_q    (ex_mem_q),
        .mem_wb_data (mem_wb_data),
        .rs1_fwd     (rs1_fwd),
        .rs2_fwd     (rs2_fwd),
        .opa         (opa),
        .opb         (opb)
    );

    alu u_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (slot_in.alu_func),
        .result (alu_out)
    );

    //////////////////////////////
    // branch condition
    //////////////////////////////

    // funct3 of the B-type word
    assign br_func = br_cond_e'(slot_in.inst[14:12]);

    // compares use forwarded values, not the raw register reads
    always_comb begin
        case (br_func)
            BR_BEQ:  cond_true = rs1_fwd == rs2_fwd;
            BR_BNE:  cond_true = rs1_fwd != rs2_fwd;
            BR_BLT:  cond_true = $signed(rs1_fwd) < $signed(rs2_fwd);
            BR_BGE:  cond_true = $signed(rs1_fwd) >= $signed(rs2_fwd);
            BR_BLTU: cond_true = rs1_fwd < rs2_fwd;
            BR_BGEU: cond_true = rs1_fwd >= rs2_fwd;
            default: cond_true = 1'b0;
        endcase
    end

    // jumps always taken, branches on condition
    always_comb begin
        result.valid        = slot_in.valid;
        result.alu_result   = alu_out;
        result.take_branch  = slot_in.uncond_branch | (slot_in.cond_branch & cond_true);
        result.dest_reg_idx = slot_in.dest_reg_idx;
    end

endmodule

// ==== src/redirect_arbiter.sv ====
// fixed-priority redirect select across ways, with JALR target alignment
`timescale 1ns/1ps
`include "ex_cfg.svh"

module redirect_arbiter (
    input  ex_pkg::ex_result_t lane_result [`EX_ISSUE_WIDTH-1:0],
    input  logic [31:0]        lane_inst [`EX_ISSUE_WIDTH-1:0],
    output ex_pkg::redirect_t  redirect
);

    // walk from the top way down
    // the last hit is the lowest way, so it wins
    always_comb begin
        redirect = '0;
        for (int w = `EX_ISSUE_WIDTH - 1; w >= 0; w--) begin
            if (lane_result[w].valid && lane_result[w].take_branch) begin
                redirect.taken = 1'b1;
                // jalr target drops bit 0
                if (lane_inst[w][6:0] == `EX_OP_JALR) begin
                    redirect.target = {lane_result[w].alu_result[`EX_XLEN-1:1], 1'b0};
                end else begin
                    redirect.target = lane_result[w].alu_result;
                end
            end
        end
    end

endmodule

// ==== src/ex_stage.sv ====
// execute stage top: issue lanes, redirect arbiter, EX/MEM and redirect registers
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage (
    input  logic                clk,
    input  logic                reset,
    input  ex_pkg::id_ex_slot_t id_ex_in [`EX_ISSUE_WIDTH-1:0],
    input  ex_pkg::fwd_ctrl_t   fwd_in [`EX_ISSUE_WIDTH-1:0],
    input  logic [`EX_XLEN-1:0] mem_wb_data [`EX_ISSUE_WIDTH-1:0],
    output ex_pkg::ex_result_t  ex_mem_out [`EX_ISSUE_WIDTH-1:0],
    output ex_pkg::redirect_t   redirect
);
    import ex_pkg::*;

    // unregistered per-way results
    ex_result_t  lane_result [`EX_ISSUE_WIDTH-1:0];
    logic [31:0] lane_inst [`EX_ISSUE_WIDTH-1:0];
    redirect_t   redirect_d;

    //////////////////////////////
    // lanes
    //////////////////////////////

    for (genvar w = 0; w < `EX_ISSUE_WIDTH; w++) begin : g_lane
        // every lane sees the registered packet as EX/MEM source
        exec_lane u_exec_lane (
            .slot_in     (id_ex_in[w]),
            .fwd         (fwd_in[w]),
            .ex_mem_q    (ex_mem_out),
            .mem_wb_data (mem_wb_data),
            .result      (lane_result[w])
        );

        // opcode source for the jalr check
        assign lane_inst[w] = id_ex_in[w].inst;
    end

    redirect_arbiter u_redirect_arbiter (
        .lane_result (lane_result),
        .lane_inst   (lane_inst),
        .redirect    (redirect_d)
    );

    //////////////////////////////
    // EX/MEM register
    //////////////////////////////

    // one packet per cycle, no stall
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
                ex_mem_out[w] <= '0;
            end
            redirect <= '0;
        end else begin
            for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
                ex_mem_out[w] <= lane_result[w];
            end
            redirect <= redirect_d;
        end
    end

endmodule

// ==== tests/tb_ex_model.svh ====
// reference functions: RV32IM ALU, branch condition and RV32 immediate decode
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// one ALU function, products taken at 64 bits
function automatic logic [31:0] calc_alu(input alu_func_e func, input logic [31:0] a,
                                         input logic [31:0] b);
    logic [63:0] a_sx;
    logic [63:0] a_zx;
    logic [63:0] b_sx;
    logic [63:0] b_zx;
    logic [63:0] p_ss;
    logic [63:0] p_su;
    logic [63:0] p_uu;
    logic [63:0] sra_wide;
    logic [31:0] flip;
    a_sx = {{32{a[31]}}, a};
    a_zx = {32'b0, a};
    b_sx = {{32{b[31]}}, b};
    b_zx = {32'b0, b};
    // 64-bit wrap of the extended operands gives the exact product
    p_ss = a_sx * b_sx;
    p_su = a_sx * b_zx;
    p_uu = a_zx * b_zx;
    sra_wide = a_sx >> b[4:0];
    // signed compare as unsigned compare with sign bits flipped
    flip = 32'h8000_0000;
    case (func)
        ALU_ADD:    calc_alu = a + b;
        ALU_SUB:    calc_alu = a + ~b + 32'd1;
        ALU_AND:    calc_alu = a & b;
        ALU_OR:     calc_alu = a | b;
        ALU_XOR:    calc_alu = a ^ b;
        ALU_SLT:    calc_alu = {31'b0, (a ^ flip) < (b ^ flip)};
        ALU_SLTU:   calc_alu = {31'b0, a < b};
        ALU_SLL:    calc_alu = a << b[4:0];
        ALU_SRL:    calc_alu = a >> b[4:0];
        ALU_SRA:    calc_alu = sra_wide[31:0];
        ALU_MUL:    calc_alu = p_uu[31:0];
        ALU_MULH:   calc_alu = p_ss[63:32];
        ALU_MULHSU: calc_alu = p_su[63:32];
        ALU_MULHU:  calc_alu = p_uu[63:32];
        default:    calc_alu = 32'b0;
    endcase
endfunction

// branch funct3 against two source values
function automatic logic branch_holds(input logic [2:0] funct3, input logic [31:0] a,
                                      input logic [31:0] b);
    logic [31:0] sa;
    logic [31:0] sb;
    sa = a ^ 32'h8000_0000;
    sb = b ^ 32'h8000_0000;
    case (funct3)
        3'b000:  branch_holds = (a == b);
        3'b001:  branch_holds = (a != b);
        3'b100:  branch_holds = (sa < sb);
        3'b101:  branch_holds = !(sa < sb);
        3'b110:  branch_holds = (a < b);
        3'b111:  branch_holds = !(a < b);
        // funct3 010/011 are not branches
        default: branch_holds = 1'b0;
    endcase
endfunction

// RV32 immediate formats, sign from inst[31]
function automatic logic [31:0] decode_imm(input opb_sel_e sel, input logic [31:0] inst);
    logic [31:0] sign;
    sign = {32{inst[31]}};
    case (sel)
        OPB_IS_I_IMM: decode_imm = {sign[31:12], inst[31:20]};
        OPB_IS_S_IMM: decode_imm = {sign[31:12], inst[31:25], inst[11:7]};
        OPB_IS_B_IMM: decode_imm = {sign[31:13], inst[31], inst[7], inst[30:25],
                                    inst[11:8], 1'b0};
        OPB_IS_U_IMM: decode_imm = {inst[31:12], 12'h000};
        OPB_IS_J_IMM: decode_imm = {sign[31:21], inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
        default:      decode_imm = 32'b0;
    endcase
endfunction

`endif

// ==== tests/tb_ex_stage.sv ====
// ex_stage testbench with clock, reset, directed and random stimulus, checks and watchdog
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_ex_stage;
    import ex_pkg::*;

    `include "tb_ex_model.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int ALU_REPS     = 4;
    // vectors per section
    localparam int N_ALU        = 14 * ALU_REPS;
    localparam int N_OPND       = 3 * 5 * 2;
    localparam int N_BR         = 6 * 4 + 2;
    localparam int N_REDIR      = 4;
    localparam int N_FWD        = 12;
    localparam int NUM_VECTORS  = N_ALU + N_OPND + N_BR + N_REDIR + N_FWD;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_VECTORS + 20) * CLK_PERIOD;

    logic                clk;
    logic                reset;
    id_ex_slot_t         id_ex_in [`EX_ISSUE_WIDTH-1:0];
    fwd_ctrl_t           fwd_in [`EX_ISSUE_WIDTH-1:0];
    logic [`EX_XLEN-1:0] mem_wb_data [`EX_ISSUE_WIDTH-1:0];
    ex_result_t          ex_mem_out [`EX_ISSUE_WIDTH-1:0];
    redirect_t           redirect;

    // predicted packet for the cycle in flight
    ex_result_t          exp_res [`EX_ISSUE_WIDTH-1:0];
    // predicted alu results now held in the EX/MEM register
    logic [`EX_XLEN-1:0] last_alu [`EX_ISSUE_WIDTH-1:0];
    integer              seed;

    ex_stage dut_i (
        .clk         (clk),
        .reset       (reset),
        .id_ex_in    (id_ex_in),
        .fwd_in      (fwd_in),
        .mem_wb_data (mem_wb_data),
        .ex_mem_out  (ex_mem_out),
        .redirect    (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the test sequence did not finish in %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // valid add of random rs1/rs2 with no branch
    function automatic id_ex_slot_t base_slot();
        id_ex_slot_t s;
        logic [31:0] r;
        s = '0;
        s.valid = 1'b1;
        s.pc = rand_word() & 32'hffff_fffc;
        s.npc = s.pc + 32'd4;
        s.inst = rand_word();
        s.rs1_value = rand_word();
        s.rs2_value = rand_word();
        s.opa_sel = OPA_IS_RS1;
        s.opb_sel = OPB_IS_RS2;
        s.alu_func = ALU_ADD;
        r = rand_word();
        s.dest_reg_idx = r[`EX_REG_IDX_W-1:0];
        base_slot = s;
    endfunction

    function automatic br_cond_e cond_at(input int i);
        case (i)
            0:       cond_at = BR_BEQ;
            1:       cond_at = BR_BNE;
            2:       cond_at = BR_BLT;
            3:       cond_at = BR_BGE;
            4:       cond_at = BR_BLTU;
            default: cond_at = BR_BGEU;
        endcase
    endfunction

    // source value after forwarding
    function automatic logic [31:0] pick_source(input fwd_src_e src,
                                                input logic [`EX_SLOT_W-1:0] slot,
                                                input logic [31:0] reg_value);
        if (src == FWD_EX_MEM) begin
            pick_source = last_alu[slot];
        end else if (src == FWD_MEM_WB) begin
            pick_source = mem_wb_data[slot];
        end else begin
            pick_source = reg_value;
        end
    endfunction

    function automatic ex_result_t predict_lane(input int w);
        id_ex_slot_t s;
        fwd_ctrl_t   f;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] a;
        logic [31:0] b;
        ex_result_t  r;
        s = id_ex_in[w];
        f = fwd_in[w];
        rs1 = pick_source(f.src_a, f.slot_a, s.rs1_value);
        rs2 = pick_source(f.src_b, f.slot_b, s.rs2_value);
        case (s.opa_sel)
            OPA_IS_RS1: a = rs1;
            OPA_IS_NPC: a = s.npc;
            OPA_IS_PC:  a = s.pc;
            default:    a = 32'b0;
        endcase
        b = (s.opb_sel == OPB_IS_RS2) ? rs2 : decode_imm(s.opb_sel, s.inst);
        r.valid = s.valid;
        r.alu_result = calc_alu(s.alu_func, a, b);
        r.take_branch = s.uncond_branch | (s.cond_branch & branch_holds(s.inst[14:12], rs1, rs2));
        r.dest_reg_idx = s.dest_reg_idx;
        predict_lane = r;
    endfunction

    // lowest valid taker wins and a jalr target is made even
    function automatic redirect_t predict_redirect();
        redirect_t rd;
        rd = '0;
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            if (!rd.taken && exp_res[w].valid && exp_res[w].take_branch) begin
                rd.taken = 1'b1;
                rd.target = exp_res[w].alu_result;
                if (id_ex_in[w].inst[6:0] == `EX_OP_JALR) begin
                    rd.target[0] = 1'b0;
                end
            end
        end
        predict_redirect = rd;
    endfunction

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_reset_state(input string tag);
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            compare_word($sformatf("%s way %0d valid", tag, w), ex_mem_out[w].valid, 0);
            compare_word($sformatf("%s way %0d take", tag, w), ex_mem_out[w].take_branch, 0);
        end
        compare_word({tag, " redirect taken"}, redirect.taken, 0);
        compare_word({tag, " redirect target"}, redirect.target, 0);
    endtask

    // issue what is driven now and check one cycle later at the falling edge
    task automatic run_cycle(input string tag);
        redirect_t exp_redir;
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            exp_res[w] = predict_lane(w);
        end
        exp_redir = predict_redirect();
        @(posedge clk);
        @(negedge clk);
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            compare_word($sformatf("%s way %0d valid", tag, w),
                         ex_mem_out[w].valid, exp_res[w].valid);
            compare_word($sformatf("%s way %0d alu_result", tag, w),
                         ex_mem_out[w].alu_result, exp_res[w].alu_result);
            compare_word($sformatf("%s way %0d take_branch", tag, w),
                         ex_mem_out[w].take_branch, exp_res[w].take_branch);
            compare_word($sformatf("%s way %0d dest_reg_idx", tag, w),
                         ex_mem_out[w].dest_reg_idx, exp_res[w].dest_reg_idx);
            last_alu[w] = exp_res[w].alu_result;
        end
        compare_word({tag, " redirect taken"}, redirect.taken, exp_redir.taken);
        if (exp_redir.taken) begin
            compare_word({tag, " redirect target"}, redirect.target, exp_redir.target);
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        logic [31:0] kv;
        seed = 32'hb848;
        reset = 1'b1;
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            id_ex_in[w] = '0;
            fwd_in[w] = '0;
            mem_wb_data[w] = '0;
            last_alu[w] = '0;
        end

        // live jumps on the inputs while reset holds
        @(negedge clk);
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            id_ex_in[w] = base_slot();
            id_ex_in[w].uncond_branch = 1'b1;
        end
        for (int c = 2; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_reset_state("in reset");
        end
        @(negedge clk);
        reset = 1'b0;
        check_reset_state("reset release");

        // every function on both ways with plain register operands
        for (int f = 0; f < 14; f++) begin
            for (int r = 0; r < ALU_REPS; r++) begin
                for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
                    id_ex_in[w] = base_slot();
                    id_ex_in[w].alu_func = alu_func_e'(f);
                    fwd_in[w] = '0;
                end
                run_cycle("alu");
            end
        end

        // npc/pc/zero against each immediate
        for (int a = 1; a <= 3; a++) begin
            for (int b = 1; b <= 5; b++) begin
                for (int r = 0; r < 2; r++) begin
                    for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
                        id_ex_in[w] = base_slot();
                        id_ex_in[w].opa_sel = opa_sel_e'(a);
                        id_ex_in[w].opb_sel = opb_sel_e'(b);
                    end
                    run_cycle("operand source");
                end
            end
        end

        // conditional branches with equal and mixed-sign pairs
        for (int c = 0; c < 6; c++) begin
            for (int r = 0; r < 4; r++) begin
                for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
                    id_ex_in[w] = base_slot();
                    id_ex_in[w].inst[6:0] = 7'b1100011;
                    id_ex_in[w].inst[14:12] = cond_at(c);
                    id_ex_in[w].opa_sel = OPA_IS_PC;
                    id_ex_in[w].opb_sel = OPB_IS_B_IMM;
                    id_ex_in[w].cond_branch = 1'b1;
                    if (r == 1 || r == 3) begin
                        id_ex_in[w].rs2_value = id_ex_in[w].rs1_value;
                    end else if (r == 2) begin
                        id_ex_in[w].rs2_value = id_ex_in[w].rs1_value ^ 32'h8000_0000;
                    end
                end
                run_cycle("branch");
            end
        end

        // jal then jalr as always-taken jumps
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            id_ex_in[w] = base_slot();
            id_ex_in[w].inst[6:0] = `EX_OP_JAL;
            id_ex_in[w].opa_sel = OPA_IS_PC;
            id_ex_in[w].opb_sel = OPB_IS_J_IMM;
            id_ex_in[w].uncond_branch = 1'b1;
        end
        run_cycle("jal");
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            id_ex_in[w] = base_slot();
            id_ex_in[w].inst[6:0] = `EX_OP_JALR;
            id_ex_in[w].opb_sel = OPB_IS_I_IMM;
            id_ex_in[w].uncond_branch = 1'b1;
        end
        run_cycle("jalr");

        //////////////////////////////
        // redirect arbitration
        //////////////////////////////

        // both ways jump and way 0 has priority
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            id_ex_in[w] = base_slot();
            id_ex_in[w].inst[6:0] = `EX_OP_JAL;
            id_ex_in[w].uncond_branch = 1'b1;
        end
        run_cycle("both taking");

        // only way 1 jumps
        id_ex_in[0].uncond_branch = 1'b0;
        run_cycle("way 1 taking");

        // jalr with odd sum
        id_ex_in[0] = base_slot();
        id_ex_in[0].inst[6:0] = `EX_OP_JALR;
        id_ex_in[0].rs1_value = id_ex_in[0].rs1_value | 32'd1;
        id_ex_in[0].rs2_value = 32'd0;
        id_ex_in[0].uncond_branch = 1'b1;
        id_ex_in[1].valid = 1'b0;
        run_cycle("jalr odd");

        // jumps on invalid slots must not redirect
        for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
            id_ex_in[w] = base_slot();
            id_ex_in[w].valid = 1'b0;
            id_ex_in[w].uncond_branch = 1'b1;
        end
        run_cycle("no valid taker");

        //////////////////////////////
        // forwarding
        //////////////////////////////

        // ex_mem draws on the previous packet and mem_wb on driven data
        for (int k = 0; k < N_FWD; k++) begin
            kv = k;
            for (int w = 0; w < `EX_ISSUE_WIDTH; w++) begin
                id_ex_in[w] = base_slot();
                id_ex_in[w].alu_func = kv[0] ? ALU_XOR : ALU_ADD;
                id_ex_in[w].inst[14:12] = cond_at(k % 6);
                id_ex_in[w].cond_branch = 1'b1;
                fwd_in[w].src_a = fwd_src_e'(k % 3);
                fwd_in[w].slot_a = kv[1];
                fwd_in[w].src_b = fwd_src_e'((k + w + 1) % 3);
                fwd_in[w].slot_b = kv[0] ^ w[0];
                mem_wb_data[w] = rand_word();
            end
            run_cycle("forwarding");
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
+incdir+tests
src/ex_pkg.sv
src/alu.sv
src/operand_select.sv
src/exec_lane.sv
src/redirect_arbiter.sv
src/ex_stage.sv
tests/tb_ex_stage.sv
